// ==== source/xt_periph_pkg.sv ====
/*
 * Shared constants and types for the PC/XT peripheral glue logic.
 * Address maps, bus widths, PPI port offsets, port B bit positions
 * and the decoded select flags used by every RTL block.
 */
package xt_periph_pkg;

    // Bus widths
    localparam int ADDR_W       = 20;
    localparam int DATA_W       = 8;
    localparam int RAM_ADDR_W   = 18;
    localparam int ROM_ADDR_W   = 16;
    localparam int IOCTL_ADDR_W = 25;

    // I/O port groups on address bits 7:5, 32 ports each
    localparam logic [2:0] IO_GROUP_DMA      = 3'd0;
    localparam logic [2:0] IO_GROUP_PIC      = 3'd1;
    localparam logic [2:0] IO_GROUP_PIT      = 3'd2;
    localparam logic [2:0] IO_GROUP_PPI      = 3'd3;
    localparam logic [2:0] IO_GROUP_DMA_PAGE = 3'd4;

    // Memory regions, 00000-3FFFF RAM and F0000-FFFFF BIOS
    localparam logic [1:0] RAM_REGION = 2'b00;
    localparam logic [3:0] ROM_REGION = 4'b1111;

    // Offsets inside the PPI window (0x60..0x62)
    localparam logic [1:0] PPI_PORT_A = 2'd0;
    localparam logic [1:0] PPI_PORT_B = 2'd1;
    localparam logic [1:0] PPI_PORT_C = 2'd2;

    // Port B bit positions
    localparam int PORTB_TIMER_GATE   = 0;
    localparam int PORTB_SPEAKER_DATA = 1;
    localparam int PORTB_KBD_RESET_N  = 6;
    localparam int PORTB_KBD_CLEAR    = 7;

    // Value returned when no source drives the bus
    localparam logic [DATA_W-1:0] IDLE_BUS_BYTE = 8'h00;

    // Decoded selects, all active high
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic dma_page;
        logic ram;
        logic rom;
    } select_t;

endpackage

// ==== source/xt_bus_if.sv ====
/*
 * CPU-side bus as seen by the peripheral block.
 * Filled from the pins at the top level and read by the decoder,
 * the memories, the keyboard port and the read mux.
 */
`timescale 1ns/1ps

interface xt_bus_if;

    logic [xt_periph_pkg::ADDR_W-1:0] address;
    logic [xt_periph_pkg::DATA_W-1:0] data_in;
    logic                             io_read_n;
    logic                             io_write_n;
    logic                             memory_read_n;
    logic                             memory_write_n;
    logic                             address_enable_n;

    modport master (
        output address, data_in, io_read_n, io_write_n,
               memory_read_n, memory_write_n, address_enable_n
    );

    // Address decode needs only the address and its enable
    modport decode (
        input address, address_enable_n
    );

    modport target (
        input address, data_in, io_read_n, io_write_n,
              memory_read_n, memory_write_n, address_enable_n
    );

endinterface

// ==== source/io_decoder.sv ====
/*
 * Address decoder for the I/O port groups 0x000-0x0FF and the RAM and
 * BIOS memory regions. Purely combinational, selects are active high.
 */
`timescale 1ns/1ps

module io_decoder (
    xt_bus_if.decode               bus_i,
    output xt_periph_pkg::select_t sel_o
);

    logic       bus_enabled;
    logic       io_window;
    logic [2:0] io_group;

    assign bus_enabled = ~bus_i.address_enable_n;

    // Only the first 256 ports are decoded here
    assign io_window = bus_enabled & ~bus_i.address[9] & ~bus_i.address[8];
    assign io_group  = bus_i.address[7:5];

    always_comb begin
        sel_o.dma      = io_window & (io_group == xt_periph_pkg::IO_GROUP_DMA);
        sel_o.pic      = io_window & (io_group == xt_periph_pkg::IO_GROUP_PIC);
        sel_o.pit      = io_window & (io_group == xt_periph_pkg::IO_GROUP_PIT);
        sel_o.ppi      = io_window & (io_group == xt_periph_pkg::IO_GROUP_PPI);
        sel_o.dma_page = io_window & (io_group == xt_periph_pkg::IO_GROUP_DMA_PAGE);

        // Memory regions from the top address bits
        sel_o.ram = bus_enabled &
                    (bus_i.address[xt_periph_pkg::ADDR_W-1 -: 2] ==
                     xt_periph_pkg::RAM_REGION);
        sel_o.rom = bus_enabled &
                    (bus_i.address[xt_periph_pkg::ADDR_W-1 -: 4] ==
                     xt_periph_pkg::ROM_REGION);
    end

endmodule

// ==== source/system_memory.sv ====
/*
 * 256 KB system RAM and 64 KB BIOS ROM with registered read data.
 * The ROM is filled through the download port, the CPU only reads it.
 */
`timescale 1ns/1ps

module system_memory (
    input  logic                                 clock,
    xt_bus_if.target                             bus_i,
    input  xt_periph_pkg::select_t               sel_i,
    input  logic                                 ioctl_download_i,
    input  logic                                 ioctl_wr_i,
    input  logic [xt_periph_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]     ioctl_data_i,
    output logic [xt_periph_pkg::DATA_W-1:0]     ram_data_o,
    output logic [xt_periph_pkg::DATA_W-1:0]     rom_data_o
);

    localparam int RAM_DEPTH = 2 ** xt_periph_pkg::RAM_ADDR_W;
    localparam int ROM_DEPTH = 2 ** xt_periph_pkg::ROM_ADDR_W;

    logic [xt_periph_pkg::DATA_W-1:0] ram [RAM_DEPTH];
    logic [xt_periph_pkg::DATA_W-1:0] rom [ROM_DEPTH];

    logic [xt_periph_pkg::RAM_ADDR_W-1:0] ram_index;
    logic [xt_periph_pkg::ROM_ADDR_W-1:0] rom_index;
    logic                                 ram_write;
    logic                                 rom_enable;
    logic                                 rom_write;

    assign ram_index = bus_i.address[xt_periph_pkg::RAM_ADDR_W-1:0];
    assign ram_write = sel_i.ram & ~bus_i.memory_write_n;

    // RAM port, read data shows the old byte during a write
    always_ff @(posedge clock) begin
        if (ram_write) begin
            ram[ram_index] <= bus_i.data_in;
        end
        if (sel_i.ram) begin
            ram_data_o <= ram[ram_index];
        end
    end

    // Download takes over the ROM port completely
    assign rom_index = ioctl_download_i ?
                       ioctl_addr_i[xt_periph_pkg::ROM_ADDR_W-1:0] :
                       bus_i.address[xt_periph_pkg::ROM_ADDR_W-1:0];

    assign rom_enable = ioctl_download_i | sel_i.rom;
    assign rom_write  = ioctl_download_i & ioctl_wr_i;

    always_ff @(posedge clock) begin
        if (rom_write) begin
            rom[rom_index] <= ioctl_data_i;
        end
        if (rom_enable) begin
            rom_data_o <= rom[rom_index];
        end
    end

endmodule

// ==== source/keyboard_port.sv ====
/*
 * Reduced PPI for the keyboard and system control ports 0x60-0x62.
 * Synchronizes the keyboard inputs, holds port B and derives the
 * speaker, timer gate, keyboard clear and keyboard reset request.
 */
`timescale 1ns/1ps

module keyboard_port (
    input  logic                             clock,
    input  logic                             reset,
    xt_bus_if.target                         bus_i,
    input  xt_periph_pkg::select_t           sel_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] keycode_i,
    input  logic                             keyboard_irq_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] port_c_i,
    input  logic                             timer2_out_i,
    output logic                             keyboard_interrupt_o,
    output logic [xt_periph_pkg::DATA_W-1:0] port_data_o,
    output logic                             timer2_gate_o,
    output logic                             speaker_out_o,
    output logic                             kbd_clear_o,
    output logic                             kbd_reset_req_o
);

    logic [xt_periph_pkg::DATA_W-1:0] keycode_meta;
    logic [xt_periph_pkg::DATA_W-1:0] keycode_sync;
    logic                             irq_meta;
    logic [xt_periph_pkg::DATA_W-1:0] port_b;
    logic                             prev_io_write_n;
    logic [1:0]                       offset;
    logic                             port_b_write;
    logic                             reset_rise;

    assign offset = bus_i.address[1:0];

    // Write strobe edge so one bus write updates port B only once
    assign port_b_write = sel_i.ppi & (offset == xt_periph_pkg::PPI_PORT_B) &
                          ~bus_i.io_write_n & prev_io_write_n;

    assign reset_rise = port_b_write &
                        bus_i.data_in[xt_periph_pkg::PORTB_KBD_RESET_N] &
                        ~port_b[xt_periph_pkg::PORTB_KBD_RESET_N];

    always_ff @(posedge clock) begin
        if (reset) begin
            keycode_meta         <= '0;
            keycode_sync         <= '0;
            irq_meta             <= 1'b0;
            keyboard_interrupt_o <= 1'b0;
            port_b               <= '0;
            prev_io_write_n      <= 1'b1;
            kbd_reset_req_o      <= 1'b0;
        end else begin
            // Keyboard source is asynchronous, two flops each
            keycode_meta         <= keycode_i;
            keycode_sync         <= keycode_meta;
            irq_meta             <= keyboard_irq_i;
            keyboard_interrupt_o <= irq_meta;
            prev_io_write_n      <= bus_i.io_write_n;
            if (port_b_write) begin
                port_b <= bus_i.data_in;
            end
            kbd_reset_req_o <= reset_rise;
        end
    end

    always_comb begin
        case (offset)
            xt_periph_pkg::PPI_PORT_A: port_data_o = keycode_sync;
            xt_periph_pkg::PPI_PORT_B: port_data_o = port_b;
            xt_periph_pkg::PPI_PORT_C: port_data_o = port_c_i;
            default:                   port_data_o = xt_periph_pkg::IDLE_BUS_BYTE;
        endcase
    end

    assign timer2_gate_o = port_b[xt_periph_pkg::PORTB_TIMER_GATE];
    assign speaker_out_o = timer2_out_i & port_b[xt_periph_pkg::PORTB_SPEAKER_DATA];
    assign kbd_clear_o   = port_b[xt_periph_pkg::PORTB_KBD_CLEAR];

endmodule

// ==== source/read_data_mux.sv ====
/*
 * Picks the byte returned to the CPU from the chipset sources.
 * Fixed priority with interrupt acknowledge first, idle byte last.
 */
`timescale 1ns/1ps

module read_data_mux (
    xt_bus_if.target                         bus_i,
    input  xt_periph_pkg::select_t           sel_i,
    input  logic                             interrupt_acknowledge_n_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] pic_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] pit_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] ppi_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] ram_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0] rom_data_i,
    output logic [xt_periph_pkg::DATA_W-1:0] data_bus_out_o,
    output logic                             data_bus_out_from_chipset_o
);

    logic io_read;
    logic memory_read;

    assign io_read     = ~bus_i.io_read_n;
    assign memory_read = ~bus_i.memory_read_n;

    always_comb begin
        data_bus_out_from_chipset_o = 1'b1;
        // Vector byte from the external PIC during INTA
        if (!interrupt_acknowledge_n_i) begin
            data_bus_out_o = pic_data_i;
        end else if (sel_i.pic && io_read) begin
            data_bus_out_o = pic_data_i;
        end else if (sel_i.pit && io_read) begin
            data_bus_out_o = pit_data_i;
        end else if (sel_i.ppi && io_read) begin
            data_bus_out_o = ppi_data_i;
        end else if (sel_i.rom && memory_read) begin
            data_bus_out_o = rom_data_i;
        end else if (sel_i.ram && memory_read) begin
            data_bus_out_o = ram_data_i;
        end else begin
            data_bus_out_o              = xt_periph_pkg::IDLE_BUS_BYTE;
            data_bus_out_from_chipset_o = 1'b0;
        end
    end

endmodule

// ==== source/xt_peripherals.sv ====
/*
 * Top level of the PC/XT peripheral glue logic.
 * Pins feed the internal bus, external chips get active-low selects.
 */
`timescale 1ns/1ps

module xt_peripherals (
    input  logic        clock,
    input  logic        reset,
    input  logic [19:0] address_i,
    input  logic [7:0]  internal_data_bus_i,
    input  logic        io_read_n_i,
    input  logic        io_write_n_i,
    input  logic        memory_read_n_i,
    input  logic        memory_write_n_i,
    input  logic        address_enable_n_i,
    input  logic        interrupt_acknowledge_n_i,
    input  logic [7:0]  pic_data_i,
    input  logic [7:0]  pit_data_i,
    output logic        dma_chip_select_n_o,
    output logic        dma_page_chip_select_n_o,
    output logic        pic_chip_select_n_o,
    output logic        pit_chip_select_n_o,
    input  logic [7:0]  keycode_i,
    input  logic        keyboard_irq_i,
    input  logic [7:0]  port_c_i,
    input  logic        timer2_out_i,
    input  logic        ioctl_download_i,
    input  logic        ioctl_wr_i,
    input  logic [24:0] ioctl_addr_i,
    input  logic [7:0]  ioctl_data_i,
    output logic [7:0]  data_bus_out_o,
    output logic        data_bus_out_from_chipset_o,
    output logic        keyboard_interrupt_o,
    output logic        timer2_gate_o,
    output logic        speaker_out_o,
    output logic        kbd_clear_o,
    output logic        kbd_reset_req_o
);

    xt_periph_pkg::select_t sel;

    logic [7:0] ppi_data;
    logic [7:0] ram_data;
    logic [7:0] rom_data;

    xt_bus_if bus ();

    assign bus.address          = address_i;
    assign bus.data_in          = internal_data_bus_i;
    assign bus.io_read_n        = io_read_n_i;
    assign bus.io_write_n       = io_write_n_i;
    assign bus.memory_read_n    = memory_read_n_i;
    assign bus.memory_write_n   = memory_write_n_i;
    assign bus.address_enable_n = address_enable_n_i;

    io_decoder u_io_decoder (
        .bus_i (bus.decode),
        .sel_o (sel)
    );

    // Selects for the chips that live outside this block
    assign dma_chip_select_n_o      = ~sel.dma;
    assign dma_page_chip_select_n_o = ~sel.dma_page;
    assign pic_chip_select_n_o      = ~sel.pic;
    assign pit_chip_select_n_o      = ~sel.pit;

    system_memory u_system_memory (
        .clock            (clock),
        .bus_i            (bus.target),
        .sel_i            (sel),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_wr_i       (ioctl_wr_i),
        .ioctl_addr_i     (ioctl_addr_i),
        .ioctl_data_i     (ioctl_data_i),
        .ram_data_o       (ram_data),
        .rom_data_o       (rom_data)
    );

    keyboard_port u_keyboard_port (
        .clock                (clock),
        .reset                (reset),
        .bus_i                (bus.target),
        .sel_i                (sel),
        .keycode_i            (keycode_i),
        .keyboard_irq_i       (keyboard_irq_i),
        .port_c_i             (port_c_i),
        .timer2_out_i         (timer2_out_i),
        .keyboard_interrupt_o (keyboard_interrupt_o),
        .port_data_o          (ppi_data),
        .timer2_gate_o        (timer2_gate_o),
        .speaker_out_o        (speaker_out_o),
        .kbd_clear_o          (kbd_clear_o),
        .kbd_reset_req_o      (kbd_reset_req_o)
    );

    read_data_mux u_read_data_mux (
        .bus_i                       (bus.target),
        .sel_i                       (sel),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
        .pic_data_i                  (pic_data_i),
        .pit_data_i                  (pit_data_i),
        .ppi_data_i                  (ppi_data),
        .ram_data_i                  (ram_data),
        .rom_data_i                  (rom_data),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

// ==== tests/xt_checker.sv ====
/*
 * Watches the DUT outputs on the falling clock edge and compares them with
 * the expectations from the testbench model. Counts checks and errors.
 */
`timescale 1ns/1ps

module xt_checker (
    input  logic       clock,
    input  logic       check_en_i,
    input  logic [3:0] dut_cs_n_i,
    input  logic [4:0] dut_ctrl_i,
    input  logic [7:0] dut_data_i,
    input  logic       dut_from_chipset_i,
    input  logic [3:0] exp_cs_n_i,
    input  logic [4:0] exp_ctrl_i,
    input  logic       data_check_i,
    input  logic [7:0] exp_data_i,
    input  logic       exp_from_chipset_i,
    output int         error_count_o,
    output int         check_count_o
);

    int errors = 0;
    int checks = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic compare_byte(input string what, input logic [7:0] actual,
                                input logic [7:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAILED at %0d ns: %s is 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
        end
    endtask

    // Inputs move 5 ns after the rising edge, so outputs are settled here
    always @(negedge clock) begin
        if (check_en_i) begin
            compare_byte("chip selects {dma, dma_page, pic, pit}",
                         {4'd0, dut_cs_n_i}, {4'd0, exp_cs_n_i});
            compare_byte("controls {irq, gate, speaker, clear, reset_req}",
                         {3'd0, dut_ctrl_i}, {3'd0, exp_ctrl_i});
            if (data_check_i) begin
                compare_byte("data bus", dut_data_i, exp_data_i);
                compare_byte("from-chipset flag", {7'd0, dut_from_chipset_i},
                             {7'd0, exp_from_chipset_i});
            end
        end
    end

endmodule

// ==== tests/tb_xt_peripherals.sv ====
/*
 * Testbench for the PC/XT peripheral glue. Drives seeded random bus cycles,
 * ROM downloads and keyboard inputs, keeps a model of RAM, ROM, port B and
 * the keyboard synchronizers, and feeds its expectations to the checker.
 */
`timescale 1ns/1ps

module tb_xt_peripherals;

    localparam int CLK_PERIOD  = 100;
    localparam int N_DECODE    = 40;
    localparam int N_RAM       = 24;
    localparam int N_ROM       = 24;
    localparam int N_ROM_WRITE = 8;
    localparam int N_PORTB     = 24;
    localparam int N_KBD       = 16;
    localparam int N_PRIO      = 16;
    localparam int N_TRANS = N_DECODE + 2 * N_RAM + 2 * N_ROM + N_ROM_WRITE +
                             2 * N_PORTB + 2 * N_KBD + 2 * N_PRIO;
    // Four cycles per transaction exceed the longest one of three
    localparam int TIMEOUT_CYCLES = N_TRANS * 4 + 50;

    logic        clock, reset;
    logic [19:0] address;
    logic [7:0]  data_bus, pic_data, pit_data, keycode, port_c, ioctl_data;
    logic        io_read_n, io_write_n, memory_read_n, memory_write_n;
    logic        address_enable_n, inta_n, keyboard_irq, timer2_out;
    logic        ioctl_download, ioctl_wr;
    logic [24:0] ioctl_addr;

    logic [7:0] dut_data;
    logic       dut_from_chipset, dma_cs_n, dma_page_cs_n, pic_cs_n, pit_cs_n;
    logic       kbd_int, timer2_gate, speaker, kbd_clear, kbd_reset_req;

    // Reference model
    logic [7:0]  ram_model [int];
    logic [7:0]  rom_model [int];
    logic [17:0] ram_addrs [$];
    logic [15:0] rom_addrs [$];
    logic [7:0]  portb_model, key_d1, key_d2;
    logic        irq_d1, irq_d2, reset_req_exp;

    // Expectations handed to the checker
    logic       check_en, data_check, exp_from_chipset;
    logic [7:0] exp_data;
    logic [3:0] exp_cs_n;
    logic [4:0] exp_ctrl;
    int         error_count, check_count;

    // Order is dma, dma_page, pic, pit
    function automatic logic [3:0] expected_cs_n(input logic [19:0] addr,
                                                 input logic aen_n);
        logic io_space;
        io_space = !aen_n && (addr[9:8] == 2'b00);
        expected_cs_n = ~{io_space && (addr[7:5] == 3'd0), io_space && (addr[7:5] == 3'd4),
                          io_space && (addr[7:5] == 3'd1), io_space && (addr[7:5] == 3'd2)};
    endfunction

    function automatic logic [7:0] expected_io_byte(input logic [19:0] addr);
        case (addr[7:5])
            3'd1: expected_io_byte = pic_data;
            3'd2: expected_io_byte = pit_data;
            default: begin
                case (addr[1:0])
                    2'd0:    expected_io_byte = key_d2;
                    2'd1:    expected_io_byte = portb_model;
                    default: expected_io_byte = port_c;
                endcase
            end
        endcase
    endfunction

    assign exp_cs_n = expected_cs_n(address, address_enable_n);
    assign exp_ctrl = {irq_d2, portb_model[0], timer2_out & portb_model[1],
                       portb_model[7], reset_req_exp};

    xt_peripherals u_xt_peripherals (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .internal_data_bus_i         (data_bus),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (memory_read_n),
        .memory_write_n_i            (memory_write_n),
        .address_enable_n_i          (address_enable_n),
        .interrupt_acknowledge_n_i   (inta_n),
        .pic_data_i                  (pic_data),
        .pit_data_i                  (pit_data),
        .dma_chip_select_n_o         (dma_cs_n),
        .dma_page_chip_select_n_o    (dma_page_cs_n),
        .pic_chip_select_n_o         (pic_cs_n),
        .pit_chip_select_n_o         (pit_cs_n),
        .keycode_i                   (keycode),
        .keyboard_irq_i              (keyboard_irq),
        .port_c_i                    (port_c),
        .timer2_out_i                (timer2_out),
        .ioctl_download_i            (ioctl_download),
        .ioctl_wr_i                  (ioctl_wr),
        .ioctl_addr_i                (ioctl_addr),
        .ioctl_data_i                (ioctl_data),
        .data_bus_out_o              (dut_data),
        .data_bus_out_from_chipset_o (dut_from_chipset),
        .keyboard_interrupt_o        (kbd_int),
        .timer2_gate_o               (timer2_gate),
        .speaker_out_o               (speaker),
        .kbd_clear_o                 (kbd_clear),
        .kbd_reset_req_o             (kbd_reset_req)
    );

    xt_checker u_xt_checker (
        .clock              (clock),
        .check_en_i         (check_en),
        .dut_cs_n_i         ({dma_cs_n, dma_page_cs_n, pic_cs_n, pit_cs_n}),
        .dut_ctrl_i         ({kbd_int, timer2_gate, speaker, kbd_clear, kbd_reset_req}),
        .dut_data_i         (dut_data),
        .dut_from_chipset_i (dut_from_chipset),
        .exp_cs_n_i         (exp_cs_n),
        .exp_ctrl_i         (exp_ctrl),
        .data_check_i       (data_check),
        .exp_data_i         (exp_data),
        .exp_from_chipset_i (exp_from_chipset),
        .error_count_o      (error_count),
        .check_count_o      (check_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Keyboard inputs seen two cycles late
    always @(posedge clock) begin
        if (reset) begin
            key_d1 <= 8'h00;
            key_d2 <= 8'h00;
            irq_d1 <= 1'b0;
            irq_d2 <= 1'b0;
        end else begin
            key_d1 <= keycode;
            key_d2 <= key_d1;
            irq_d1 <= keyboard_irq;
            irq_d2 <= irq_d1;
        end
    end

    // Next drive point with fresh random values on the free-running inputs
    task automatic next_cycle();
        @(posedge clock);
        #5;
        reset_req_exp = 1'b0;
        keycode       = 8'($urandom);
        keyboard_irq  = 1'($urandom);
        port_c        = 8'($urandom);
        timer2_out    = 1'($urandom);
        pic_data      = 8'($urandom);
        pit_data      = 8'($urandom);
    endtask

    task automatic release_bus();
        next_cycle();
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        memory_read_n    = 1'b1;
        memory_write_n   = 1'b1;
        address_enable_n = 1'b1;
        inta_n           = 1'b1;
        ioctl_download   = 1'b0;
        ioctl_wr         = 1'b0;
        data_check       = 1'b1;
        exp_data         = 8'h00;
        exp_from_chipset = 1'b0;
    endtask

    task automatic io_write(input logic [19:0] addr, input logic [7:0] value);
        next_cycle();
        address          = addr;
        data_bus         = value;
        address_enable_n = 1'b0;
        io_write_n       = 1'b0;
        release_bus();
        if (addr[9:5] == 5'd3 && addr[1:0] == 2'd1) begin
            reset_req_exp = value[6] & ~portb_model[6];
            portb_model   = value;
        end
    endtask

    task automatic io_read(input logic [19:0] addr);
        next_cycle();
        address          = addr;
        address_enable_n = 1'b0;
        io_read_n        = 1'b0;
        exp_data         = expected_io_byte(addr);
        exp_from_chipset = 1'b1;
        release_bus();
    endtask

    task automatic mem_write(input logic [19:0] addr, input logic [7:0] value);
        next_cycle();
        address          = addr;
        data_bus         = value;
        address_enable_n = 1'b0;
        memory_write_n   = 1'b0;
        release_bus();
        // Only RAM takes CPU writes
        if (addr[19:18] == 2'b00) begin
            ram_model[int'(addr[17:0])] = value;
        end
    endtask

    task automatic mem_read(input logic [19:0] addr, input logic [7:0] expected);
        next_cycle();
        address          = addr;
        address_enable_n = 1'b0;
        memory_read_n    = 1'b0;
        data_check       = 1'b0;
        next_cycle();
        data_check       = 1'b1;
        exp_data         = expected;
        exp_from_chipset = 1'b1;
        release_bus();
    endtask

    task automatic inta_cycle();
        next_cycle();
        address          = 20'($urandom);
        address_enable_n = 1'($urandom);
        io_read_n        = 1'($urandom);
        memory_read_n    = 1'($urandom);
        inta_n           = 1'b0;
        exp_data         = pic_data;
        exp_from_chipset = 1'b1;
        release_bus();
    endtask

    initial begin
        int          idx;
        logic [17:0] ram_a;
        logic [15:0] rom_a;
        void'($urandom(43931));
        reset = 1'b1;
        {address, data_bus, pic_data, pit_data, keycode, port_c} = '0;
        {io_read_n, io_write_n, memory_read_n, memory_write_n} = 4'hF;
        {address_enable_n, inta_n, keyboard_irq, timer2_out} = 4'b1100;
        {ioctl_download, ioctl_wr, ioctl_addr, ioctl_data} = '0;
        {portb_model, reset_req_exp, check_en, data_check, exp_data} = '0;
        exp_from_chipset = 1'b0;
        repeat (4) @(posedge clock);
        #5;
        reset = 1'b0;
        release_bus();
        check_en = 1'b1;
        repeat (N_DECODE) begin
            next_cycle();
            address          = {10'd0, 10'($urandom)};
            address_enable_n = 1'($urandom);
        end
        release_bus();
        repeat (N_RAM) begin
            ram_a = 18'($urandom);
            ram_addrs.push_back(ram_a);
            mem_write({2'b00, ram_a}, 8'($urandom));
        end
        repeat (N_RAM) begin
            idx = int'($urandom_range(ram_addrs.size() - 1, 0));
            mem_read({2'b00, ram_addrs[idx]}, ram_model[int'(ram_addrs[idx])]);
        end
        // ROM download of one byte per clock
        repeat (N_ROM) begin
            next_cycle();
            rom_a          = 16'($urandom);
            ioctl_download = 1'b1;
            ioctl_wr       = 1'b1;
            ioctl_addr     = {9'd0, rom_a};
            ioctl_data     = 8'($urandom);
            rom_model[int'(rom_a)] = ioctl_data;
            rom_addrs.push_back(rom_a);
        end
        release_bus();
        repeat (N_ROM_WRITE) begin
            idx = int'($urandom_range(rom_addrs.size() - 1, 0));
            mem_write({4'hF, rom_addrs[idx]}, 8'($urandom));
        end
        repeat (N_ROM) begin
            idx = int'($urandom_range(rom_addrs.size() - 1, 0));
            mem_read({4'hF, rom_addrs[idx]}, rom_model[int'(rom_addrs[idx])]);
        end
        repeat (N_PORTB) begin
            io_write(20'h00061, 8'($urandom));
            io_read(20'h00061);
        end
        repeat (N_KBD) begin
            io_read(20'h00060);
            io_read(20'h00062);
        end
        repeat (N_PRIO) begin
            inta_cycle();
            io_read({12'h000, 3'd2, 5'($urandom)});
        end
        // Last check runs on the falling edge before this one
        @(posedge clock);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
source/xt_periph_pkg.sv
source/xt_bus_if.sv
source/io_decoder.sv
source/system_memory.sv
source/keyboard_port.sv
source/read_data_mux.sv
source/xt_peripherals.sv
tests/xt_checker.sv
tests/tb_xt_peripherals.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_xt_peripherals -f sources.f -o sim_xt_peripherals \
    && ./obj_dir/sim_xt_peripherals | tee /dev/stderr | grep "TESTS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
